// File: all.f
+incdir+src
src/aux_pkg.sv
src/aux_tx_ctrl.sv
src/aux_native_encoder.sv
src/aux_manchester_tx.sv
src/aux_native_tx_top.sv
bench/aux_clk_gen.sv
bench/aux_native_tx_sva.sv
bench/aux_native_tx_tb.sv

// File: bench/aux_clk_gen.sv
`timescale 1ns/1ns
// Testbench clock and reset source
// 4 ns clock, active low reset held for 10 cycles
module aux_clk_gen
(
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS = 2;

  initial
  begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;    // Release just after an edge
  end

endmodule

// File: bench/aux_native_tx_sva.sv
`timescale 1ns/1ns
// AUX native transmit protocol checks
// Request gating while the line is busy, single-cycle done, idle line level
module aux_native_tx_sva
(
  input logic clk,
  input logic rst_n,
  input logic req_ready,
  input logic done,
  input logic aux_tx,
  input logic aux_tx_en
);

  // No new request while a frame is on the line
  a_busy_blocks_req: assert property (@(posedge clk) disable iff (!rst_n)
    aux_tx_en |-> !req_ready)
    else $error("req_ready high while aux_tx_en is high");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)    // One cycle only
    else $error("done high for two cycles in a row");

  // Line parked low when not driven
  a_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    !aux_tx_en |-> !aux_tx)
    else $error("aux_tx high while aux_tx_en is low");

endmodule

bind aux_native_tx_top aux_native_tx_sva i_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_ready (req_ready),
  .done      (done),
  .aux_tx    (aux_tx),
  .aux_tx_en (aux_tx_en)
);

// File: bench/aux_native_tx_tb.sv
`timescale 1ns/1ns
`include "aux_settings.svh"
// AUX native transmit testbench
// Random native requests and sink replies, Manchester line decoding of each
// frame and comparison against frames built from the native encoding rules
module aux_native_tx_tb
  import aux_pkg::*;
();

  localparam int NUM_TXN      = 40;
  localparam int CLK_NS       = 4;
  localparam int HB           = `AUX_HALF_BIT_CYCLES;
  localparam int PRE          = `AUX_PREAMBLE_BITS;
  localparam int LIMIT        = `AUX_RETRY_LIMIT;
  // Longest frame: preamble, SYNC, 20 bytes, STOP
  localparam int FRAME_CYCLES = 2 * HB * (PRE + 8 + 8 * `AUX_MSG_MAX_BYTES);
  localparam int FRAME_WAIT   = FRAME_CYCLES + 64;
  localparam longint WATCHDOG_NS =
    longint'(NUM_TXN) * (FRAME_CYCLES + 48) * (LIMIT + 1) * CLK_NS * 2 + 100;

  logic            clk;
  logic            rst_n;
  logic            req_vld;
  aux_native_req_t req;
  logic [7:0]      wr_data;
  logic            reply_vld;
  aux_reply_e      reply;
  logic [7:0]      reply_done_count;
  logic            req_ready;
  logic            done;
  aux_status_e     status;
  logic            aux_tx;
  logic            aux_tx_en;

  integer          seed;
  int              errors = 0;
  int              frame_cnt = 0;         // Frames decoded off the line
  int              checked_cnt = 0;       // Frames compared so far
  int              expected_frames = 0;
  logic            timed_out = 1'b0;
  aux_native_req_t cur_req;
  logic [7:0]      cur_data [16];
  logic            halves [$];            // Half-bit levels of the current frame
  int              hb_phase = 0;
  logic            in_frame = 1'b0;
  logic [7:0]      frame_q [$];           // Last decoded frame
  logic [7:0]      exp_q [$];             // Model frame

  aux_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  aux_native_tx_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_vld          (req_vld),
    .req              (req),
    .wr_data          (wr_data),
    .reply_vld        (reply_vld),
    .reply            (reply),
    .reply_done_count (reply_done_count),
    .req_ready        (req_ready),
    .done             (done),
    .status           (status),
    .aux_tx           (aux_tx),
    .aux_tx_en        (aux_tx_en)
  );

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  task automatic report_fail(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_run();
    $display("Run finished: %0d errors, %0d frames decoded", errors, frame_cnt);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  // SYNC and STOP, two bit times high then two low
  task automatic check_sync_stop(input int first_bit, input string name);
    logic lvl;
    for (int i = 0; i < 4; i++)
    begin
      lvl = (i < 2);
      if (halves[2 * (first_bit + i)] !== lvl || halves[2 * (first_bit + i) + 1] !== lvl)
        report_fail($sformatf("%s bit %0d has the wrong line level", name, i));
    end
  endtask

  // Strip framing and collect data bytes
  task automatic decode_frame();
    int         nbits;
    int         nbytes;
    int         pos;
    logic [7:0] b;
    nbits = halves.size() / 2;
    b = '0;
    frame_q.delete();
    if (halves.size() % 2 != 0 || nbits < PRE + 8 || (nbits - PRE - 8) % 8 != 0)
      report_fail($sformatf("frame of %0d half-bits has no valid length", halves.size()));
    else
    begin
      nbytes = (nbits - PRE - 8) / 8;
      for (int i = 0; i < PRE; i++)
        if (halves[2 * i] !== 1'b0 || halves[2 * i + 1] !== 1'b1)
          report_fail($sformatf("preamble bit %0d is not a Manchester zero", i));
      check_sync_stop(PRE, "SYNC");
      for (int j = 0; j < nbytes; j++)
      begin
        for (int k = 0; k < 8; k++)
        begin
          pos = 2 * (PRE + 4 + 8 * j + k);
          if (halves[pos] === halves[pos + 1])
            report_fail($sformatf("byte %0d bit %0d has no mid-bit transition", j, k));
          b = {b[6:0], halves[pos]};     // MSB first, first half carries the bit
        end
        frame_q.push_back(b);
      end
      check_sync_stop(PRE + 4 + 8 * nbytes, "STOP");
    end
    frame_cnt++;
  endtask

  // Line decoder, sampled at negedge while the line is driven
  always @(negedge clk)
  begin
    if (aux_tx_en === 1'b1)
    begin
      if (hb_phase == HB / 2)
        halves.push_back(aux_tx);        // Middle of the half-bit
      hb_phase = (hb_phase == HB - 1) ? 0 : hb_phase + 1;
      in_frame = 1'b1;
    end
    else if (in_frame)
    begin
      decode_frame();
      in_frame = 1'b0;
      hb_phase = 0;
      halves.delete();
    end
  end

  // Model frame, skip counts data bytes already taken by the sink
  task automatic build_expected(input int skip);
    exp_q.delete();
    if (cur_req.cmd == AUX_CMD_READ)
      exp_q.push_back({4'b1001, cur_req.addr[19:16]});
    else
      exp_q.push_back({4'b1000, cur_req.addr[19:16]});
    exp_q.push_back(cur_req.addr[15:8]);
    exp_q.push_back(cur_req.addr[7:0]);
    exp_q.push_back(cur_req.len - 8'(skip));
    if (cur_req.cmd == AUX_CMD_WRITE)
      for (int j = skip; j <= int'(cur_req.len); j++)
        exp_q.push_back(cur_data[j]);
    expected_frames++;
  endtask

  task automatic compare_frame();
    if (frame_q.size() != exp_q.size())
      report_fail($sformatf("frame has %0d bytes, expected %0d", frame_q.size(), exp_q.size()));
    else
      for (int i = 0; i < exp_q.size(); i++)
        if (frame_q[i] !== exp_q[i])
          report_fail($sformatf("frame byte %0d is %02h, expected %02h",
                                i, frame_q[i], exp_q[i]));
  endtask

  // Returns on a posedge once a new frame is decoded
  task automatic wait_frame();
    int cycles;
    cycles = 0;
    while (frame_cnt == checked_cnt && cycles < FRAME_WAIT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (frame_cnt == checked_cnt)
    begin
      $display("Timeout at %0t ns: no frame on the line after %0d cycles", $time, cycles);
      errors++;
      timed_out = 1'b1;
    end
    else
    begin
      checked_cnt = frame_cnt;
      compare_frame();
    end
  endtask

  // Header with byte 0, then one data byte per clock
  task automatic send_request();
    @(posedge clk);
    #1;
    req_vld = 1'b1;
    req     = cur_req;
    wr_data = cur_data[0];
    @(posedge clk);
    #1;
    req_vld = 1'b0;
    for (int j = 1; j <= int'(cur_req.len); j++)
    begin
      wr_data = cur_data[j];
      @(posedge clk);
      #1;
    end
  endtask

  // Ends at the negedge where done is due
  task automatic send_reply(input aux_reply_e kind, input logic [7:0] count);
    repeat (rand_below(3)) @(posedge clk);
    #1;
    reply_vld        = 1'b1;
    reply            = kind;
    reply_done_count = count;
    @(posedge clk);
    #1;
    reply_vld = 1'b0;
    @(negedge clk);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns before the run completed", $time);
    errors++;
    end_run();
  end

  initial
  begin
    int          mode;
    int          nacks;
    int          nreplies;
    int          k;
    aux_reply_e  kind;
    aux_status_e exp_status;
    seed             = 32'h4b68;
    req_vld          = 1'b0;
    req              = '0;
    wr_data          = '0;
    reply_vld        = 1'b0;
    reply            = AUX_REPLY_ACK;
    reply_done_count = '0;
    kind             = AUX_REPLY_ACK;
    k                = 0;
    @(posedge rst_n);
    @(negedge clk);
    if (req_ready !== 1'b1 || aux_tx_en !== 1'b0 || done !== 1'b0 || aux_tx !== 1'b0)
      report_fail("outputs not idle after reset");
    for (int t = 0; t < NUM_TXN && !timed_out; t++)
    begin
      cur_req.cmd  = rand_below(2) ? AUX_CMD_READ : AUX_CMD_WRITE;
      cur_req.addr = 20'(rand_below(1 << 20));
      cur_req.len  = 8'(rand_below(16));
      for (int j = 0; j < 16; j++)
        cur_data[j] = 8'(rand_below(256));
      mode = (t < 3) ? t : rand_below(3);   // ACK, retries then ACK, retry limit
      if (mode == 0)
        nacks = 0;
      else if (mode == 1)
        nacks = 1 + rand_below(LIMIT);
      else
        nacks = LIMIT + 1;
      nreplies   = (mode == 2) ? nacks : nacks + 1;
      exp_status = (mode == 2) ? AUX_STATUS_FAIL : AUX_STATUS_OK;
      @(negedge clk);
      if (req_ready !== 1'b1)
        report_fail("req_ready low before a new request");
      send_request();
      build_expected(0);
      for (int r = 0; r < nreplies && !timed_out; r++)
      begin
        wait_frame();
        if (!timed_out)
        begin
          if (r < nacks)
          begin
            kind = rand_below(2) ? AUX_REPLY_DEFER : AUX_REPLY_NACK;
            k    = rand_below(int'(cur_req.len) + 1);    // At most len bytes taken
            send_reply(kind, 8'(k));
          end
          else
            send_reply(AUX_REPLY_ACK, 8'(rand_below(256)));
          if (r == nreplies - 1)
          begin
            if (done !== 1'b1)
              report_fail("done missing one cycle after the final reply");
            if (status !== exp_status)
              report_fail($sformatf("status %0d, expected %0d", status, exp_status));
            if (req_ready !== 1'b1)
              report_fail("req_ready low after done");
          end
          else
          begin
            if (done !== 1'b0)
              report_fail("done raised on a retried reply");
            // Only a write NACK shortens the replay
            if (kind == AUX_REPLY_NACK && cur_req.cmd == AUX_CMD_WRITE)
              build_expected(k);
            else
              build_expected(0);
          end
        end
      end
      if (!timed_out)
      begin
        repeat (8) @(negedge clk);     // Line must stay quiet
        if (aux_tx_en !== 1'b0 || frame_cnt != expected_frames)
          report_fail($sformatf("%0d frames seen, %0d expected", frame_cnt, expected_frames));
      end
    end
    end_run();
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the AUX native transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module aux_native_tx_tb -o aux_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/aux_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

// File: src/aux_manchester_tx.sv
`timescale 1ns/1ns
`include "aux_settings.svh"
// AUX Manchester-II serializer
// Buffers message bytes and sends preamble, SYNC, data MSB first and STOP
// Pulses frame_sent once STOP is done
module aux_manchester_tx
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] msg_byte,
  input  logic       msg_vld,
  output logic       aux_tx,
  output logic       aux_tx_en,
  output logic       frame_sent
);

  localparam int IDX_W = $clog2(`AUX_MSG_MAX_BYTES);
  localparam int HB_W  = (`AUX_HALF_BIT_CYCLES > 1) ? $clog2(`AUX_HALF_BIT_CYCLES) : 1;

  typedef enum logic [2:0] {PH_IDLE, PH_PRE, PH_SYNC, PH_DATA, PH_STOP} tx_phase_e;

  tx_phase_e        phase;
  logic [7:0]       msg_buf [`AUX_MSG_MAX_BYTES];
  logic [IDX_W-1:0] wr_cnt;      // Bytes buffered
  logic [IDX_W-1:0] rd_ptr;      // Byte on the line
  logic [HB_W-1:0]  hb_tmr;      // Half-bit timer
  logic             half_sel;    // Second half of the bit
  logic [4:0]       bit_idx;
  logic             hb_end;
  logic             bit_end;
  logic             frame_end;
  logic             data_bit;

  assign hb_end    = (hb_tmr == HB_W'(`AUX_HALF_BIT_CYCLES - 1));
  assign bit_end   = hb_end && half_sel;
  assign frame_end = (phase == PH_STOP) && bit_end && (bit_idx == 5'd3);
  assign data_bit  = msg_buf[rd_ptr][~bit_idx[2:0]];    // MSB first

  always_ff @(posedge clk)
  begin
    if (msg_vld)
      msg_buf[wr_cnt] <= msg_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_cnt <= '0;
    else if (frame_end)
      wr_cnt <= '0;                // Ready for the next message
    else if (msg_vld)
      wr_cnt <= wr_cnt + 1'b1;
  end

  // Framer
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= PH_IDLE;
      hb_tmr     <= '0;
      half_sel   <= 1'b0;
      bit_idx    <= '0;
      rd_ptr     <= '0;
      frame_sent <= 1'b0;
    end
    else
    begin
      frame_sent <= frame_end;
      if (phase == PH_IDLE)
      begin
        hb_tmr   <= '0;
        half_sel <= 1'b0;
        bit_idx  <= '0;
        if (msg_vld)
          phase <= PH_PRE;           // First byte starts the frame
      end
      else
      begin
        hb_tmr <= hb_end ? '0 : hb_tmr + 1'b1;
        if (hb_end)
          half_sel <= ~half_sel;
        if (bit_end)
        begin
          bit_idx <= bit_idx + 1'b1;
          case (phase)
            PH_PRE:
            begin
              if (bit_idx == 5'(`AUX_PREAMBLE_BITS - 1))
              begin
                phase   <= PH_SYNC;
                bit_idx <= '0;
              end
            end
            PH_SYNC:
            begin
              if (bit_idx == 5'd3)
              begin
                phase   <= PH_DATA;
                bit_idx <= '0;
                rd_ptr  <= '0;
              end
            end
            PH_DATA:
            begin
              if (bit_idx == 5'd7)
              begin
                bit_idx <= '0;
                if (rd_ptr == wr_cnt - 1'b1)
                  phase <= PH_STOP;    // Buffer drained
                else
                  rd_ptr <= rd_ptr + 1'b1;
              end
            end
            PH_STOP:
            begin
              if (bit_idx == 5'd3)
              begin
                phase   <= PH_IDLE;
                bit_idx <= '0;
              end
            end
            default: phase <= PH_IDLE;
          endcase
        end
      end
    end
  end

  // Line level per phase
  always_comb
  begin
    case (phase)
      PH_PRE:           aux_tx = half_sel;              // Zero is low then high
      PH_SYNC, PH_STOP: aux_tx = ~bit_idx[1];           // Two bits high, two low
      PH_DATA:          aux_tx = data_bit ^ half_sel;   // One is high then low
      default:          aux_tx = 1'b0;
    endcase
  end

  assign aux_tx_en = (phase != PH_IDLE);

endmodule

// File: src/aux_native_encoder.sv
`timescale 1ns/1ns
`include "aux_settings.svh"
// AUX native message encoder
// Packs a request into CMD|ADDR, ADDR, ADDR, LEN and data bytes, one per clock
// Keeps the message so a retransmit can replay it, with LEN and data
// shortened by the bytes the sink already took
module aux_native_encoder
  import aux_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  aux_native_req_t req,
  input  logic            native_req_vld,
  input  logic [7:0]      wr_data,
  input  logic            retrans,
  input  logic [7:0]      done_count,
  output logic [7:0]      msg_byte,
  output logic            msg_vld
);

  localparam int IDX_W = $clog2(`AUX_MSG_MAX_BYTES);
  localparam logic [IDX_W-1:0] LEN_IDX  = IDX_W'(3);   // LEN byte slot
  localparam logic [IDX_W-1:0] DATA_IDX = IDX_W'(4);   // First data byte slot

  logic [7:0]       msg_mem [`AUX_MSG_MAX_BYTES];      // Full message store
  logic [3:0]       cmd_code;
  logic [IDX_W-1:0] in_cnt;      // Data bytes captured so far
  logic [IDX_W-1:0] in_max;      // Data bytes expected
  logic [IDX_W-1:0] rd_idx;      // Output counter
  logic [IDX_W-1:0] last_idx;    // Slot of the final byte
  logic [7:0]       skip;        // Data bytes dropped on replay
  logic             is_write;
  logic             capturing;
  logic [8:0]       jump_idx;    // Slot after LEN on replay
  logic             stop_at_len;

  // Native command nibble
  always_comb
  begin
    case (req.cmd)
      AUX_CMD_WRITE: cmd_code = 4'b1000;
      AUX_CMD_READ:  cmd_code = 4'b1001;
      default:       cmd_code = 4'b1000;
    endcase
  end

  assign capturing   = (in_cnt != in_max);
  assign jump_idx    = 9'(DATA_IDX) + {1'b0, skip};
  assign stop_at_len = (jump_idx > {4'b0, last_idx});  // Nothing left after LEN

  // Message store, header on the request cycle, data as it streams in
  always_ff @(posedge clk)
  begin
    if (native_req_vld)
    begin
      msg_mem[0]        <= {cmd_code, req.addr[19:16]};
      msg_mem[1]        <= req.addr[15:8];
      msg_mem[2]        <= req.addr[7:0];
      msg_mem[LEN_IDX]  <= req.len;
      msg_mem[DATA_IDX] <= wr_data;    // Byte 0 rides with the request
    end
    else if (capturing)
    begin
      msg_mem[DATA_IDX + in_cnt] <= wr_data;
    end
  end

  // Input counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_cnt   <= '0;
      in_max   <= '0;
      last_idx <= '0;
      is_write <= 1'b0;
    end
    else if (native_req_vld)
    begin
      is_write <= (req.cmd == AUX_CMD_WRITE);
      if (req.cmd == AUX_CMD_WRITE)
      begin
        in_cnt   <= IDX_W'(1);                            // Byte 0 already in
        in_max   <= IDX_W'(req.len[3:0]) + IDX_W'(1);
        last_idx <= DATA_IDX + IDX_W'(req.len[3:0]);
      end
      else
      begin
        in_cnt   <= '0;                                   // Read carries no data
        in_max   <= '0;
        last_idx <= LEN_IDX;
      end
    end
    else if (capturing)
    begin
      in_cnt <= in_cnt + 1'b1;
    end
  end

  // Output counter, fresh send or replay
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_idx  <= '0;
      skip    <= '0;
      msg_vld <= 1'b0;
    end
    else if (native_req_vld)
    begin
      rd_idx  <= '0;
      skip    <= '0;
      msg_vld <= 1'b1;
    end
    else if (retrans)
    begin
      rd_idx  <= '0;
      skip    <= is_write ? done_count : 8'd0;   // Read replays unchanged
      msg_vld <= 1'b1;
    end
    else if (msg_vld)
    begin
      if (rd_idx == last_idx || (rd_idx == LEN_IDX && stop_at_len))
        msg_vld <= 1'b0;                         // Last byte out
      else if (rd_idx == LEN_IDX)
        rd_idx <= jump_idx[IDX_W-1:0];           // Skip accepted data
      else
        rd_idx <= rd_idx + 1'b1;
    end
  end

  // LEN is patched on the way out
  always_comb
  begin
    if (rd_idx == LEN_IDX)
      msg_byte = msg_mem[LEN_IDX] - skip;
    else
      msg_byte = msg_mem[rd_idx];
  end

endmodule

// File: src/aux_native_tx_top.sv
`timescale 1ns/1ns
// AUX native transmit top
// Controller, native encoder and Manchester serializer in a chain
module aux_native_tx_top
  import aux_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_vld,
  input  aux_native_req_t req,
  input  logic [7:0]      wr_data,
  input  logic            reply_vld,
  input  aux_reply_e      reply,
  input  logic [7:0]      reply_done_count,
  output logic            req_ready,
  output logic            done,
  output aux_status_e     status,
  output logic            aux_tx,
  output logic            aux_tx_en
);

  logic       native_req_vld;
  logic       retrans;
  logic [7:0] done_count;     // Held with retrans
  logic [7:0] msg_byte;
  logic       msg_vld;
  logic       frame_sent;

  aux_tx_ctrl i_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_vld          (req_vld),
    .frame_sent       (frame_sent),
    .reply_vld        (reply_vld),
    .reply            (reply),
    .reply_done_count (reply_done_count),
    .req_ready        (req_ready),
    .native_req_vld   (native_req_vld),
    .retrans          (retrans),
    .done_count       (done_count),
    .done             (done),
    .status           (status)
  );

  aux_native_encoder i_enc (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req),
    .native_req_vld (native_req_vld),
    .wr_data        (wr_data),
    .retrans        (retrans),
    .done_count     (done_count),
    .msg_byte       (msg_byte),
    .msg_vld        (msg_vld)
  );

  aux_manchester_tx i_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .msg_byte   (msg_byte),
    .msg_vld    (msg_vld),
    .aux_tx     (aux_tx),
    .aux_tx_en  (aux_tx_en),
    .frame_sent (frame_sent)
  );

endmodule

// File: src/aux_pkg.sv
// AUX native transmit types
// Request struct plus command, reply, status and controller state enums
package aux_pkg;

  typedef enum logic [1:0] {
    AUX_CMD_WRITE = 2'b00,
    AUX_CMD_READ  = 2'b01
  } aux_cmd_e;

  // Host request, 30 bits
  typedef struct packed {
    aux_cmd_e    cmd;
    logic [19:0] addr;
    logic [7:0]  len;    // Byte count minus one, 0 to 15
  } aux_native_req_t;

  typedef enum logic [1:0] {
    AUX_REPLY_ACK   = 2'b00,
    AUX_REPLY_NACK  = 2'b01,
    AUX_REPLY_DEFER = 2'b10
  } aux_reply_e;

  typedef enum logic {
    AUX_STATUS_OK   = 1'b0,
    AUX_STATUS_FAIL = 1'b1
  } aux_status_e;

  // Transaction controller FSM
  typedef enum logic [1:0] {IDLE, SEND, WAIT_REPLY} aux_ctrl_state_e;

endpackage

// File: src/aux_settings.svh
// AUX native transmit sizing and timing
// Message length, Manchester framing and retry limit
`ifndef AUX_SETTINGS_SVH
`define AUX_SETTINGS_SVH

// Four header bytes plus up to 16 data bytes
`define AUX_MSG_MAX_BYTES 20

// Manchester zero bits ahead of SYNC
`define AUX_PREAMBLE_BITS 16

// Clocks per Manchester half-bit
`define AUX_HALF_BIT_CYCLES 2

// Retransmissions allowed per request
`define AUX_RETRY_LIMIT 3

`endif

// File: src/aux_tx_ctrl.sv
`timescale 1ns/1ns
`include "aux_settings.svh"
// AUX native transaction controller
// Admits host requests, waits for the frame and the reply,
// retries on NACK or DEFER up to the limit and reports the result
module aux_tx_ctrl
  import aux_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_vld,
  input  logic        frame_sent,
  input  logic        reply_vld,
  input  aux_reply_e  reply,
  input  logic [7:0]  reply_done_count,
  output logic        req_ready,
  output logic        native_req_vld,
  output logic        retrans,
  output logic [7:0]  done_count,
  output logic        done,
  output aux_status_e status
);

  localparam int RETRY_W = $clog2(`AUX_RETRY_LIMIT + 1);

  aux_ctrl_state_e    state;
  logic [RETRY_W-1:0] retry_cnt;     // Retransmissions issued
  logic               retry_left;

  assign req_ready      = (state == IDLE);
  assign native_req_vld = req_vld && req_ready;     // Straight to the encoder
  assign retry_left     = (retry_cnt != RETRY_W'(`AUX_RETRY_LIMIT));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      retry_cnt  <= '0;
      retrans    <= 1'b0;
      done_count <= '0;
      done       <= 1'b0;
      status     <= AUX_STATUS_OK;
    end
    else
    begin
      retrans <= 1'b0;   // Pulses
      done    <= 1'b0;
      case (state)
        IDLE:
        begin
          if (req_vld)
          begin
            state     <= SEND;
            retry_cnt <= '0;
          end
        end
        SEND:
        begin
          if (frame_sent)
            state <= WAIT_REPLY;
        end
        WAIT_REPLY:
        begin
          if (reply_vld)
          begin
            if (reply == AUX_REPLY_ACK)
            begin
              done   <= 1'b1;
              status <= AUX_STATUS_OK;
              state  <= IDLE;
            end
            else if (retry_left)
            begin
              retrans    <= 1'b1;
              retry_cnt  <= retry_cnt + 1'b1;
              done_count <= (reply == AUX_REPLY_NACK) ? reply_done_count : 8'd0;
              state      <= SEND;
            end
            else
            begin
              done   <= 1'b1;                 // Out of retries
              status <= AUX_STATUS_FAIL;
              state  <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule
